// File: list.f
src/umi_pkg.sv
src/umi_width_cfg_pkg.sv
src/umi_cmd_split.sv
src/umi_async_fifo.sv
src/umi_fifo_width.sv
verification/tb_umi_fifo_width.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the UMI width converter testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_umi_fifo_width \
   -f list.f \
   -o sim_umi_fifo_width

./obj_dir/sim_umi_fifo_width 2>&1 | tee sim.log

if grep -qF "** FAIL **" sim.log; then
   echo "Simulation failed"
   exit 1
fi

echo "Simulation passed"

// File: src/umi_async_fifo.sv
/* Dual-clock FIFO with Gray-coded pointers and optional
   pseudo-random write pushback for stress testing */
`default_nettype none

module umi_async_fifo
  #(parameter int dw    = 32,
    parameter int depth = 4   // Power of two
    )
   (
    // Write side
    input  logic          wr_clk,
    input  logic          wr_nreset,
    input  logic          wr_en,
    input  logic [dw-1:0] wr_din,
    input  logic          wr_chaosmode,
    output logic          wr_full,
    // Read side
    input  logic          rd_clk,
    input  logic          rd_nreset,
    input  logic          rd_en,
    output logic [dw-1:0] rd_dout,
    output logic          rd_empty
    );

   localparam int aw_ptr = $clog2(depth);
   localparam int pw     = aw_ptr + 1;   // Extra wrap bit
   localparam logic [pw-1:0] full_mask = pw'(3) << (pw - 2);

   logic [dw-1:0] mem [depth];

   logic [pw-1:0] wr_bin, wr_bin_next, wr_gray, wr_gray_next;
   logic [pw-1:0] rd_bin, rd_bin_next, rd_gray, rd_gray_next;
   logic [pw-1:0] rq_sync1, rq_sync2;   // Read pointer in write domain
   logic [pw-1:0] wq_sync1, wq_sync2;   // Write pointer in read domain
   logic          full_q;
   logic [15:0]   lfsr;
   logic          wr_write;
   logic          rd_read;

   function automatic logic [pw-1:0] gray2bin(input logic [pw-1:0] g);
      logic [pw-1:0] b;
      b[pw-1] = g[pw-1];
      for (int i = pw - 2; i >= 0; i--)
      begin
         b[i] = b[i+1] ^ g[i];
      end
      return b;
   endfunction

   //##########################################################################
   // Write domain
   //##########################################################################

   assign wr_full  = full_q | (wr_chaosmode & lfsr[0]);   // Chaos fakes a full FIFO
   assign wr_write = wr_en & ~wr_full;

   assign wr_bin_next  = wr_bin + pw'(wr_write);
   assign wr_gray_next = wr_bin_next ^ (wr_bin_next >> 1);

   always_ff @(posedge wr_clk or negedge wr_nreset)
   begin
      if (!wr_nreset)
      begin
         wr_bin   <= '0;
         wr_gray  <= '0;
         full_q   <= 1'b0;
         rq_sync1 <= '0;
         rq_sync2 <= '0;
         lfsr     <= 16'h0001;
      end
      else
      begin
         wr_bin   <= wr_bin_next;
         wr_gray  <= wr_gray_next;
         full_q   <= (wr_gray_next ^ rq_sync2) == full_mask;   // Top two bits differ
         rq_sync1 <= rd_gray;
         rq_sync2 <= rq_sync1;
         lfsr     <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
      end
   end

   always_ff @(posedge wr_clk)
   begin
      if (wr_write)
         mem[wr_bin[aw_ptr-1:0]] <= wr_din;
   end

   //##########################################################################
   // Read domain
   //##########################################################################

   assign rd_read = rd_en & ~rd_empty;
   assign rd_dout = mem[rd_bin[aw_ptr-1:0]];   // Head entry, shown ahead

   assign rd_bin_next  = rd_bin + pw'(rd_read);
   assign rd_gray_next = rd_bin_next ^ (rd_bin_next >> 1);

   always_ff @(posedge rd_clk or negedge rd_nreset)
   begin
      if (!rd_nreset)
      begin
         rd_bin   <= '0;
         rd_gray  <= '0;
         rd_empty <= 1'b1;
         wq_sync1 <= '0;
         wq_sync2 <= '0;
      end
      else
      begin
         rd_bin   <= rd_bin_next;
         rd_gray  <= rd_gray_next;
         rd_empty <= rd_gray_next == wq_sync2;
         wq_sync1 <= wr_gray;
         wq_sync2 <= wq_sync1;
      end
   end

   //##########################################################################
   // Checks
   //##########################################################################

   // Occupancy seen through the synchronized read pointer never passes depth
   a_no_overflow: assert property (@(posedge wr_clk) disable iff (!wr_nreset)
      wr_write |-> pw'(wr_bin - gray2bin(rq_sync2)) != pw'(depth));

   a_no_underflow: assert property (@(posedge rd_clk) disable iff (!rd_nreset)
      rd_read |-> gray2bin(wq_sync2) != rd_bin);

endmodule

`default_nettype wire

// File: src/umi_cmd_split.sv
/* Splits one wide UMI transaction into output-width pieces,
   keeping the unsent remainder in a latch between pieces */
`default_nettype none

module umi_cmd_split
  (
   input  logic                                umi_in_clk,
   input  logic                                umi_in_nreset,
   // Wide input side
   input  logic                                in_valid,
   input  logic [umi_pkg::cw-1:0]              in_cmd,
   input  logic [umi_width_cfg_pkg::aw-1:0]    in_dstaddr,
   input  logic [umi_width_cfg_pkg::aw-1:0]    in_srcaddr,
   input  logic [umi_width_cfg_pkg::idw-1:0]   in_data,
   output logic                                in_ready,
   // Piece towards the FIFO
   input  logic                                wr_full,
   output logic                                wr_en,
   output logic [umi_pkg::cw-1:0]              piece_cmd,
   output logic [umi_width_cfg_pkg::aw-1:0]    piece_dstaddr,
   output logic [umi_width_cfg_pkg::aw-1:0]    piece_srcaddr,
   output logic [umi_width_cfg_pkg::odw-1:0]   piece_data
   );

   typedef enum logic {split_idle, split_cont} split_state_e;

   split_state_e                        state;

   // Remainder latch
   logic [umi_pkg::cw-1:0]              lat_cmd;
   logic [umi_width_cfg_pkg::aw-1:0]    lat_dstaddr;
   logic [umi_width_cfg_pkg::aw-1:0]    lat_srcaddr;
   logic [umi_width_cfg_pkg::idw-1:0]   lat_data;

   // Transaction being worked on
   logic [umi_pkg::cw-1:0]              cur_cmd;
   logic [umi_width_cfg_pkg::aw-1:0]    cur_dstaddr;
   logic [umi_width_cfg_pkg::aw-1:0]    cur_srcaddr;
   logic [umi_width_cfg_pkg::idw-1:0]   cur_data;
   umi_pkg::umi_opcode_e                cur_opcode;
   logic [umi_pkg::size_w-1:0]          cur_size;
   logic [umi_pkg::len_w-1:0]           cur_len;

   logic [8:0]                          len_p1;   // Holds len+1 units up to 256
   logic [8:0]                          cap;      // Units per output beat
   logic                                has_data;
   logic                                split;
   logic [umi_pkg::len_w-1:0]           piece_len;
   logic [umi_pkg::len_w-1:0]           rem_len;
   logic [umi_pkg::cw-1:0]              rem_cmd;
   logic                                write;

   //##########################################################################
   // Current transaction and splitting rule
   //##########################################################################

   assign cur_cmd     = (state == split_cont) ? lat_cmd     : in_cmd;
   assign cur_dstaddr = (state == split_cont) ? lat_dstaddr : in_dstaddr;
   assign cur_srcaddr = (state == split_cont) ? lat_srcaddr : in_srcaddr;
   assign cur_data    = (state == split_cont) ? lat_data    : in_data;

   assign cur_opcode = umi_pkg::umi_opcode_e'(cur_cmd[umi_pkg::opcode_lsb +: umi_pkg::opcode_w]);
   assign cur_size   = cur_cmd[umi_pkg::size_lsb +: umi_pkg::size_w];
   assign cur_len    = cur_cmd[umi_pkg::len_lsb +: umi_pkg::len_w];

   assign len_p1 = {1'b0, cur_len} + 9'd1;
   assign cap    = 9'(umi_width_cfg_pkg::out_bytes >> cur_size);

   // Reads carry no payload and are never split
   assign has_data = cur_opcode inside {umi_pkg::req_write, umi_pkg::req_posted,
                                        umi_pkg::resp_read};
   assign split    = has_data & (len_p1 > cap);

   assign piece_len = split ? 8'(cap - 9'd1) : cur_len;
   assign rem_len   = 8'(len_p1 - cap - 9'd1);   // Only meaningful when split

   always_comb
   begin
      piece_cmd = cur_cmd;
      piece_cmd[umi_pkg::len_lsb +: umi_pkg::len_w] = piece_len;
      rem_cmd = cur_cmd;
      rem_cmd[umi_pkg::len_lsb +: umi_pkg::len_w] = rem_len;
   end

   assign piece_dstaddr = cur_dstaddr;
   assign piece_srcaddr = cur_srcaddr;
   assign piece_data    = cur_data[umi_width_cfg_pkg::odw-1:0];

   //##########################################################################
   // Handshake and latch
   //##########################################################################

   assign wr_en    = (state == split_cont) | in_valid;
   assign write    = wr_en & ~wr_full;
   assign in_ready = ~wr_full & (state == split_idle);   // Stall while pieces remain

   always_ff @(posedge umi_in_clk or negedge umi_in_nreset)
   begin
      if (!umi_in_nreset)
         state <= split_idle;
      else if (write)
         state <= split ? split_cont : split_idle;
   end

   always_ff @(posedge umi_in_clk)
   begin
      if (write)
      begin
         lat_cmd     <= rem_cmd;
         lat_dstaddr <= cur_dstaddr + umi_width_cfg_pkg::out_bytes;
         lat_srcaddr <= cur_srcaddr + umi_width_cfg_pkg::out_bytes;
         lat_data    <= cur_data >> umi_width_cfg_pkg::odw;   // Next slice to bottom
      end
   end

   //##########################################################################
   // Checks
   //##########################################################################

   // A split write holds off new input on the next edge
   a_cont_stall: assert property (@(posedge umi_in_clk) disable iff (!umi_in_nreset)
      (write && split) |=> !in_ready);

   // Units wider than the output beat cannot be split
   a_size_fits: assert property (@(posedge umi_in_clk) disable iff (!umi_in_nreset)
      in_valid |-> in_cmd[umi_pkg::size_lsb +: umi_pkg::size_w] <=
                   umi_width_cfg_pkg::max_size);

   a_opcode_known: assert property (@(posedge umi_in_clk) disable iff (!umi_in_nreset)
      in_valid |-> in_cmd[umi_pkg::opcode_lsb +: umi_pkg::opcode_w] inside
         {umi_pkg::req_read, umi_pkg::req_write, umi_pkg::req_posted,
          umi_pkg::resp_read, umi_pkg::resp_write});

endmodule

`default_nettype wire

// File: src/umi_fifo_width.sv
/* UMI width converter: splits wide transactions into narrow beats
   and carries them across clock domains, with a static bypass */
`default_nettype none

module umi_fifo_width
  (
   input  logic                                bypass,      // Static, change when idle
   input  logic                                chaosmode,   // Random FIFO pushback
   // Input side
   input  logic                                umi_in_clk,
   input  logic                                umi_in_nreset,
   input  logic                                umi_in_valid,
   input  logic [umi_pkg::cw-1:0]              umi_in_cmd,
   input  logic [umi_width_cfg_pkg::aw-1:0]    umi_in_dstaddr,
   input  logic [umi_width_cfg_pkg::aw-1:0]    umi_in_srcaddr,
   input  logic [umi_width_cfg_pkg::idw-1:0]   umi_in_data,
   output logic                                umi_in_ready,
   // Output side
   input  logic                                umi_out_clk,
   input  logic                                umi_out_nreset,
   input  logic                                umi_out_ready,
   output logic                                umi_out_valid,
   output logic [umi_pkg::cw-1:0]              umi_out_cmd,
   output logic [umi_width_cfg_pkg::aw-1:0]    umi_out_dstaddr,
   output logic [umi_width_cfg_pkg::aw-1:0]    umi_out_srcaddr,
   output logic [umi_width_cfg_pkg::odw-1:0]   umi_out_data,
   // Status
   output logic                                fifo_full,
   output logic                                fifo_empty
   );

   logic                                     split_ready;
   logic                                     wr_en;
   logic [umi_pkg::cw-1:0]                   piece_cmd;
   logic [umi_width_cfg_pkg::aw-1:0]         piece_dstaddr;
   logic [umi_width_cfg_pkg::aw-1:0]         piece_srcaddr;
   logic [umi_width_cfg_pkg::odw-1:0]        piece_data;
   logic [umi_width_cfg_pkg::fifo_dw-1:0]    fifo_dout;

   umi_cmd_split u_split
     (.umi_in_clk    (umi_in_clk),
      .umi_in_nreset (umi_in_nreset),
      .in_valid      (umi_in_valid & ~bypass),   // FIFO path idle in bypass
      .in_cmd        (umi_in_cmd),
      .in_dstaddr    (umi_in_dstaddr),
      .in_srcaddr    (umi_in_srcaddr),
      .in_data       (umi_in_data),
      .in_ready      (split_ready),
      .wr_full       (fifo_full),
      .wr_en         (wr_en),
      .piece_cmd     (piece_cmd),
      .piece_dstaddr (piece_dstaddr),
      .piece_srcaddr (piece_srcaddr),
      .piece_data    (piece_data));

   umi_async_fifo #(.dw    (umi_width_cfg_pkg::fifo_dw),
                    .depth (umi_width_cfg_pkg::fifo_depth))
   u_fifo
     (.wr_clk       (umi_in_clk),
      .wr_nreset    (umi_in_nreset),
      .wr_en        (wr_en),
      .wr_din       ({piece_data, piece_srcaddr, piece_dstaddr, piece_cmd}),
      .wr_chaosmode (chaosmode),
      .wr_full      (fifo_full),
      .rd_clk       (umi_out_clk),
      .rd_nreset    (umi_out_nreset),
      .rd_en        (umi_out_ready & ~bypass),
      .rd_dout      (fifo_dout),
      .rd_empty     (fifo_empty));

   //##########################################################################
   // Bypass multiplexer
   //##########################################################################

   assign umi_out_cmd     = bypass ? umi_in_cmd : fifo_dout[0 +: umi_pkg::cw];
   assign umi_out_dstaddr = bypass ? umi_in_dstaddr :
                            fifo_dout[umi_pkg::cw +: umi_width_cfg_pkg::aw];
   assign umi_out_srcaddr = bypass ? umi_in_srcaddr :
                            fifo_dout[umi_pkg::cw + umi_width_cfg_pkg::aw +: umi_width_cfg_pkg::aw];
   assign umi_out_data    = bypass ? umi_in_data[umi_width_cfg_pkg::odw-1:0] :
                            fifo_dout[umi_width_cfg_pkg::fifo_dw-1 -: umi_width_cfg_pkg::odw];
   assign umi_out_valid   = bypass ? umi_in_valid  : ~fifo_empty;
   assign umi_in_ready    = bypass ? umi_out_ready : split_ready;

endmodule

`default_nettype wire

// File: src/umi_pkg.sv
/* UMI command format: field positions and widths inside the 32-bit
   command word, and the opcode encoding */
`default_nettype none

package umi_pkg;

   //##########################################################################
   // Command word layout
   //##########################################################################

   // Width of the full command word
   localparam int cw = 32;

   // Opcode field, cmd[4:0]
   localparam int opcode_lsb = 0;
   localparam int opcode_w   = 5;

   // Size field, cmd[7:5], one unit is 2**size bytes
   localparam int size_lsb = 5;
   localparam int size_w   = 3;

   // Length field, cmd[15:8], transaction has len+1 units
   localparam int len_lsb = 8;
   localparam int len_w   = 8;

   // Upper bits hold qos, prot, eom, eof, ex, user, err and hostid.
   // They pass through the converter untouched.

   //##########################################################################
   // Opcodes
   //##########################################################################

   typedef enum logic [opcode_w-1:0]
   {
      req_read   = 5'h01,   // No payload on the request
      resp_read  = 5'h02,   // Carries read data
      req_write  = 5'h03,
      resp_write = 5'h04,   // Ack only
      req_posted = 5'h05    // Write without response
   } umi_opcode_e;

endpackage

`default_nettype wire

// File: src/umi_width_cfg_pkg.sv
/* Sizing of the UMI width converter */
`default_nettype none

package umi_width_cfg_pkg;

   localparam int idw = 256;   // Input data bus
   localparam int odw = 64;    // Output data bus
   localparam int aw  = 64;    // Both address buses

   // Entries in the clock-crossing FIFO
   localparam int fifo_depth = 4;

   // Bytes moved per output beat
   localparam int out_bytes = odw / 8;

   // Largest size code whose unit still fits one output beat
   localparam int max_size = 3;

   // One FIFO entry packs data, srcaddr, dstaddr and cmd
   localparam int fifo_dw = umi_pkg::cw + 2 * aw + odw;

endpackage

`default_nettype wire

// File: verification/tb_umi_fifo_width.sv
/* Testbench for the UMI width converter: directed and random traffic
   checked against a splitting model by assertions */
`default_nettype none

module tb_umi_fifo_width;

   logic                                bypass;
   logic                                chaosmode;
   logic                                umi_in_clk;
   logic                                umi_in_nreset;
   logic                                umi_in_valid;
   logic [umi_pkg::cw-1:0]              umi_in_cmd;
   logic [umi_width_cfg_pkg::aw-1:0]    umi_in_dstaddr;
   logic [umi_width_cfg_pkg::aw-1:0]    umi_in_srcaddr;
   logic [umi_width_cfg_pkg::idw-1:0]   umi_in_data;
   logic                                umi_in_ready;
   logic                                umi_out_clk;
   logic                                umi_out_nreset;
   logic                                umi_out_ready;
   logic                                umi_out_valid;
   logic [umi_pkg::cw-1:0]              umi_out_cmd;
   logic [umi_width_cfg_pkg::aw-1:0]    umi_out_dstaddr;
   logic [umi_width_cfg_pkg::aw-1:0]    umi_out_srcaddr;
   logic [umi_width_cfg_pkg::odw-1:0]   umi_out_data;
   logic                                fifo_full;
   logic                                fifo_empty;

   // Expected pieces, oldest first
   logic [umi_pkg::cw-1:0]              exp_cmd_q[$];
   logic [umi_width_cfg_pkg::aw-1:0]    exp_dst_q[$];
   logic [umi_width_cfg_pkg::aw-1:0]    exp_src_q[$];
   logic [umi_width_cfg_pkg::odw-1:0]   exp_data_q[$];
   logic [umi_pkg::cw-1:0]              head_cmd;
   logic [umi_width_cfg_pkg::aw-1:0]    head_dst;
   logic [umi_width_cfg_pkg::aw-1:0]    head_src;
   logic [umi_width_cfg_pkg::odw-1:0]   head_data;
   int                                  q_count;
   int                                  stall_left;   // Edges with umi_in_ready held low
   int                                  check_errors;
   int                                  other_errors;
   int                                  seed;
   logic                                rand_ready;
   logic                                full_seen;
   string                               test_name;

   // Bypass path compare: valid, fields and ready
   logic [2+umi_pkg::cw+2*umi_width_cfg_pkg::aw+umi_width_cfg_pkg::odw-1:0] byp_exp;
   logic [2+umi_pkg::cw+2*umi_width_cfg_pkg::aw+umi_width_cfg_pkg::odw-1:0] byp_act;

   assign byp_exp = {umi_in_valid, umi_in_cmd, umi_in_dstaddr, umi_in_srcaddr,
                     umi_in_data[umi_width_cfg_pkg::odw-1:0], umi_out_ready};
   assign byp_act = {umi_out_valid, umi_out_cmd, umi_out_dstaddr, umi_out_srcaddr,
                     umi_out_data, umi_in_ready};

   umi_fifo_width uut (.*);

   always #5 umi_in_clk = ~umi_in_clk;

   always
   begin
      #3;
      forever #5 umi_out_clk = ~umi_out_clk;   // Trails umi_in_clk by 3
   end

   //##########################################################################
   // Reference model
   //##########################################################################

   task automatic refresh_head();
      q_count = exp_cmd_q.size();
      if (q_count != 0)
      begin
         head_cmd  = exp_cmd_q[0];
         head_dst  = exp_dst_q[0];
         head_src  = exp_src_q[0];
         head_data = exp_data_q[0];
      end
   endtask

   task automatic push_piece(input logic [umi_pkg::cw-1:0] cmd,
                             input logic [umi_width_cfg_pkg::aw-1:0] dst,
                             input logic [umi_width_cfg_pkg::aw-1:0] src,
                             input logic [umi_width_cfg_pkg::odw-1:0] data);
      exp_cmd_q.push_back(cmd);
      exp_dst_q.push_back(dst);
      exp_src_q.push_back(src);
      exp_data_q.push_back(data);
      refresh_head();
   endtask

   // Cuts one accepted transaction into output-beat pieces
   task automatic model_split(input logic [umi_pkg::cw-1:0] cmd,
                              input logic [umi_width_cfg_pkg::aw-1:0] dst,
                              input logic [umi_width_cfg_pkg::aw-1:0] src,
                              input logic [umi_width_cfg_pkg::idw-1:0] data);
      logic [umi_pkg::cw-1:0]          piece;
      logic [umi_pkg::opcode_w-1:0]    opc;
      int                              units;
      int                              cap;
      int                              pieces;
      opc    = cmd[umi_pkg::opcode_lsb +: umi_pkg::opcode_w];
      units  = int'(cmd[umi_pkg::len_lsb +: umi_pkg::len_w]) + 1;
      cap    = umi_width_cfg_pkg::out_bytes >> cmd[umi_pkg::size_lsb +: umi_pkg::size_w];
      pieces = 0;
      piece  = cmd;
      while ((opc == umi_pkg::req_write || opc == umi_pkg::req_posted ||
              opc == umi_pkg::resp_read) && units > cap)
      begin
         piece[umi_pkg::len_lsb +: umi_pkg::len_w] = 8'(cap - 1);
         push_piece(piece, dst, src, data[umi_width_cfg_pkg::odw-1:0]);
         units  = units - cap;
         dst    = dst + umi_width_cfg_pkg::out_bytes;
         src    = src + umi_width_cfg_pkg::out_bytes;
         data   = data >> umi_width_cfg_pkg::odw;
         pieces = pieces + 1;
      end
      piece[umi_pkg::len_lsb +: umi_pkg::len_w] = 8'(units - 1);   // Whole remainder
      push_piece(piece, dst, src, data[umi_width_cfg_pkg::odw-1:0]);
      stall_left = pieces;
   endtask

   always @(posedge umi_in_clk)
   begin
      if (umi_in_valid && umi_in_ready && !bypass)
         model_split(umi_in_cmd, umi_in_dstaddr, umi_in_srcaddr, umi_in_data);
      else if (stall_left > 0)
         stall_left = stall_left - 1;
      if (fifo_full)
         full_seen = 1'b1;
   end

   always @(posedge umi_out_clk)
   begin
      if (umi_out_nreset && !bypass && umi_out_valid && umi_out_ready && q_count != 0)
      begin
         exp_cmd_q.delete(0);
         exp_dst_q.delete(0);
         exp_src_q.delete(0);
         exp_data_q.delete(0);
         refresh_head();
      end
   end

   always @(posedge umi_out_clk)
   begin
      #1;
      umi_out_ready = rand_ready ? 1'($random(seed)) : 1'b1;
   end

   //##########################################################################
   // Checks
   //##########################################################################

   beat_expected: assert property (@(negedge umi_out_clk) disable iff (!umi_out_nreset)
      (!bypass && umi_out_valid && umi_out_ready) |-> q_count != 0)
   else
   begin
      other_errors++;
      $display("An output beat arrived in %s when none was expected", test_name);
   end

   beat_cmd: assert property (@(negedge umi_out_clk) disable iff (!umi_out_nreset)
      (!bypass && umi_out_valid && umi_out_ready && q_count != 0) |-> umi_out_cmd == head_cmd)
   else
   begin
      check_errors++;
      $display("Error %s: cmd expected %h actual %h", test_name, head_cmd, umi_out_cmd);
   end

   beat_dstaddr: assert property (@(negedge umi_out_clk) disable iff (!umi_out_nreset)
      (!bypass && umi_out_valid && umi_out_ready && q_count != 0) |->
         umi_out_dstaddr == head_dst)
   else
   begin
      check_errors++;
      $display("Error %s: dstaddr expected %h actual %h", test_name, head_dst, umi_out_dstaddr);
   end

   beat_srcaddr: assert property (@(negedge umi_out_clk) disable iff (!umi_out_nreset)
      (!bypass && umi_out_valid && umi_out_ready && q_count != 0) |->
         umi_out_srcaddr == head_src)
   else
   begin
      check_errors++;
      $display("Error %s: srcaddr expected %h actual %h", test_name, head_src, umi_out_srcaddr);
   end

   beat_data: assert property (@(negedge umi_out_clk) disable iff (!umi_out_nreset)
      (!bypass && umi_out_valid && umi_out_ready && q_count != 0) |-> umi_out_data == head_data)
   else
   begin
      check_errors++;
      $display("Error %s: data expected %h actual %h", test_name, head_data, umi_out_data);
   end

   // Input held off while the splitter still owes pieces
   in_stall: assert property (@(negedge umi_in_clk) disable iff (!umi_in_nreset)
      (!bypass && stall_left != 0) |-> !umi_in_ready)
   else
   begin
      check_errors++;
      $display("Error %s: umi_in_ready expected 0 actual %b", test_name, umi_in_ready);
   end

   bypass_path: assert property (@(negedge umi_out_clk) bypass |-> byp_act == byp_exp)
   else
   begin
      check_errors++;
      $display("Error %s: bypass expected %h actual %h", test_name, byp_exp, byp_act);
   end

   //##########################################################################
   // Stimulus
   //##########################################################################

   function automatic logic [umi_pkg::cw-1:0] make_cmd(input umi_pkg::umi_opcode_e opc,
                                                       input int size, input int len);
      logic [umi_pkg::cw-1:0] cmd;
      cmd = $random(seed);   // Upper fields random
      cmd[umi_pkg::opcode_lsb +: umi_pkg::opcode_w] = opc;
      cmd[umi_pkg::size_lsb +: umi_pkg::size_w]     = size[umi_pkg::size_w-1:0];
      cmd[umi_pkg::len_lsb +: umi_pkg::len_w]       = len[umi_pkg::len_w-1:0];
      return cmd;
   endfunction

   function automatic logic [umi_pkg::cw-1:0] rand_cmd();
      umi_pkg::umi_opcode_e opc;
      int                   size;
      case ({$random(seed)} % 5)
         0:       opc = umi_pkg::req_read;
         1:       opc = umi_pkg::req_write;
         2:       opc = umi_pkg::req_posted;
         3:       opc = umi_pkg::resp_read;
         default: opc = umi_pkg::resp_write;
      endcase
      size = {$random(seed)} % (umi_width_cfg_pkg::max_size + 1);
      // Payload fits one input beat
      return make_cmd(opc, size, {$random(seed)} % ((umi_width_cfg_pkg::idw / 8) >> size));
   endfunction

   function automatic logic [umi_width_cfg_pkg::idw-1:0] rand_data();
      logic [umi_width_cfg_pkg::idw-1:0] d;
      for (int i = 0; i < umi_width_cfg_pkg::idw / 32; i++)
      begin
         d[i*32 +: 32] = $random(seed);
      end
      return d;
   endfunction

   // Holds one transaction on the input until it is taken
   task automatic send_txn(input logic [umi_pkg::cw-1:0] cmd,
                           input logic [umi_width_cfg_pkg::aw-1:0] dst,
                           input logic [umi_width_cfg_pkg::aw-1:0] src,
                           input logic [umi_width_cfg_pkg::idw-1:0] data);
      int waited;
      waited         = 0;
      umi_in_valid   = 1'b1;
      umi_in_cmd     = cmd;
      umi_in_dstaddr = dst;
      umi_in_srcaddr = src;
      umi_in_data    = data;
      @(posedge umi_in_clk);
      while (!umi_in_ready && waited < 200)
      begin
         waited++;
         @(posedge umi_in_clk);
      end
      if (!umi_in_ready)
      begin
         other_errors++;
         $display("Timeout in %s: the input was never accepted", test_name);
      end
      #1;
      umi_in_valid = 1'b0;
   endtask

   task automatic wait_drain();
      int waited;
      waited = 0;
      while (q_count != 0 && waited < 1000)
      begin
         waited++;
         @(posedge umi_in_clk);
      end
      if (q_count != 0)
      begin
         other_errors++;
         $display("Timeout in %s: %0d expected beats never came out", test_name, q_count);
      end
      @(posedge umi_in_clk);
      #1;
   endtask

   initial
   begin
      seed           = 32'hed2e0e5e;
      check_errors   = 0;
      other_errors   = 0;
      q_count        = 0;
      stall_left     = 0;
      full_seen      = 1'b0;
      rand_ready     = 1'b0;
      test_name      = "reset";
      umi_in_clk     = 1'b0;
      umi_out_clk    = 1'b0;
      bypass         = 1'b0;
      chaosmode      = 1'b0;
      umi_in_nreset  = 1'b0;
      umi_out_nreset = 1'b0;
      umi_in_valid   = 1'b0;
      umi_in_cmd     = '0;
      umi_in_dstaddr = '0;
      umi_in_srcaddr = '0;
      umi_in_data    = '0;
      umi_out_ready  = 1'b0;
      repeat (2) @(posedge umi_in_clk);
      #1;
      umi_in_nreset  = 1'b1;
      umi_out_nreset = 1'b1;
      @(negedge umi_in_clk);
      assert (!umi_out_valid && umi_in_ready && fifo_empty)
      else
      begin
         check_errors++;
         $display("Error %s: valid ready empty expected 011 actual %b%b%b", test_name,
                  umi_out_valid, umi_in_ready, fifo_empty);
      end
      @(posedge umi_in_clk);
      #1;

      test_name = "single_write";
      send_txn(make_cmd(umi_pkg::req_write, 3, 0), 64'h1000, 64'h2000, rand_data());
      wait_drain();

      test_name = "long_write";   // Four pieces of length 7
      send_txn(make_cmd(umi_pkg::req_write, 0, 31), 64'h4000_0000, 64'h8000_0010, rand_data());
      wait_drain();

      test_name = "long_read";
      send_txn(make_cmd(umi_pkg::req_read, 0, 200), 64'h5000, 64'h6000, rand_data());
      wait_drain();

      test_name  = "random_stream";
      chaosmode  = 1'b1;
      rand_ready = 1'b1;
      full_seen  = 1'b0;
      for (int i = 0; i < 60; i++)
      begin
         if ({$random(seed)} % 4 == 0)
         begin
            @(posedge umi_in_clk);   // Idle gap
            #1;
         end
         send_txn(rand_cmd(), {$random(seed), $random(seed)},
                  {$random(seed), $random(seed)}, rand_data());
      end
      wait_drain();
      assert (full_seen)
      else
      begin
         other_errors++;
         $display("fifo_full was never seen high in %s", test_name);
      end
      chaosmode = 1'b0;

      test_name = "bypass";
      bypass    = 1'b1;
      for (int i = 0; i < 20; i++)
      begin
         umi_in_valid   = 1'($random(seed));
         umi_in_cmd     = rand_cmd();
         umi_in_dstaddr = {$random(seed), $random(seed)};
         umi_in_srcaddr = {$random(seed), $random(seed)};
         umi_in_data    = rand_data();
         @(posedge umi_in_clk);
         #1;
      end
      umi_in_valid = 1'b0;
      @(posedge umi_in_clk);
      #1;
      bypass     = 1'b0;
      rand_ready = 1'b0;
      repeat (4) @(posedge umi_in_clk);

      $display("Errors: %0d check, %0d other", check_errors, other_errors);
      if (check_errors + other_errors == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

endmodule

`default_nettype wire
